/* rtl/mul_pkg.sv */
package mul_pkg;

  // *********************************************************************
  // Widths.
  // *********************************************************************
  localparam int XLEN   = 32;
  localparam int PROD_W = 2 * XLEN;
  // Operands carry two extra sign bits so that 2x and -2x fit.
  localparam int EXT_W  = XLEN + 2;
  localparam int PP_NUM = EXT_W / 2;

  // *********************************************************************
  // Types.
  // *********************************************************************
  // Encoding follows the funct3 field of the RV32M multiply group.
  typedef enum logic [1:0] {
    MUL    = 2'b00,
    MULH   = 2'b01,
    MULHSU = 2'b10,
    MULHU  = 2'b11
  } mul_op_e;

  typedef struct packed {
    mul_op_e          op;
    logic [XLEN-1:0]  rs1;
    logic [XLEN-1:0]  rs2;
  } mul_req_t;

  // Booth rows, each one already shifted to its weight.
  typedef logic [PP_NUM-1:0][PROD_W-1:0] pp_array_t;

  typedef struct packed {
    logic [PROD_W-1:0] sum;
    logic [PROD_W-1:0] carry;
  } csa_pair_t;

endpackage

/* rtl/mul_booth_r4.sv */
`timescale 1ns/1ps

module mul_booth_r4 import mul_pkg::*; (
  input  mul_req_t  req_i,
  output pp_array_t pp_o
);

  logic             rs1_signed;
  logic             rs2_signed;
  logic [EXT_W-1:0] rs1_ext;
  logic [EXT_W-1:0] rs2_ext;
  logic [EXT_W-1:0] x_pos;
  logic [EXT_W-1:0] x_dbl;
  logic [EXT_W-1:0] x_neg;
  logic [EXT_W-1:0] x_neg_dbl;
  logic [EXT_W:0]   scan;

  // Signed for MUL and MULH, MULHSU only for rs1.
  assign rs1_signed = (req_i.op != MULHU);
  assign rs2_signed = (req_i.op == MUL) || (req_i.op == MULH);

  assign rs1_ext = {{2{rs1_signed & req_i.rs1[XLEN-1]}}, req_i.rs1};
  assign rs2_ext = {{2{rs2_signed & req_i.rs2[XLEN-1]}}, req_i.rs2};

  assign x_pos     = rs1_ext;
  assign x_dbl     = {rs1_ext[EXT_W-2:0], 1'b0};
  assign x_neg     = ~rs1_ext + 1'b1;
  assign x_neg_dbl = {x_neg[EXT_W-2:0], 1'b0};

  // Implicit zero below bit 0 starts the scan.
  assign scan = {rs2_ext, 1'b0};

  function automatic logic [EXT_W-1:0] booth_pick(input logic [2:0] grp);
    logic [EXT_W-1:0] pick;
    case (grp)
      3'b001, 3'b010: pick = x_pos;
      3'b011:         pick = x_dbl;
      3'b100:         pick = x_neg_dbl;
      3'b101, 3'b110: pick = x_neg;
      default:        pick = '0;
    endcase
    return pick;
  endfunction

  for (genvar i = 0; i < PP_NUM; i++) begin : g_pp
    logic [EXT_W-1:0]  pp_sel;
    logic [PROD_W-1:0] pp_ext;

    assign pp_sel = booth_pick(scan[2*i +: 3]);
    // Sign extension keeps the row sum exact modulo 2^64.
    assign pp_ext = {{(PROD_W - EXT_W){pp_sel[EXT_W-1]}}, pp_sel};
    assign pp_o[i] = pp_ext << (2 * i);
  end

endmodule

/* rtl/mul_csa_tree.sv */
`timescale 1ns/1ps

module mul_csa_tree import mul_pkg::*; (
  input  pp_array_t pp_i,
  output csa_pair_t csa_o
);

  // *********************************************************************
  // Tree shape, derived from the row count.
  // *********************************************************************
  function automatic int next_rows(input int n);
    return (n / 3) * 2 + (n % 3);
  endfunction

  function automatic int rows_at(input int lvl);
    int n;
    int k;
    n = PP_NUM;
    for (k = 0; k < lvl; k++) begin
      n = next_rows(n);
    end
    return n;
  endfunction

  function automatic int num_levels();
    int n;
    int l;
    n = PP_NUM;
    l = 0;
    while (n > 2) begin
      n = next_rows(n);
      l++;
    end
    return l;
  endfunction

  localparam int LVLS = num_levels();

  // Row r of level l, only the first rows_at(l) entries are live.
  wire [PROD_W-1:0] row [LVLS+1][PP_NUM];

  for (genvar i = 0; i < PP_NUM; i++) begin : g_in
    assign row[0][i] = pp_i[i];
  end

  // *********************************************************************
  // Compressor levels.
  // *********************************************************************
  for (genvar l = 0; l < LVLS; l++) begin : g_lvl
    localparam int N = rows_at(l);
    localparam int G = N / 3;

    for (genvar g = 0; g < G; g++) begin : g_csa
      logic [PROD_W-1:0] a;
      logic [PROD_W-1:0] b;
      logic [PROD_W-1:0] c;
      logic [PROD_W-1:0] maj;

      assign a   = row[l][3*g];
      assign b   = row[l][3*g+1];
      assign c   = row[l][3*g+2];
      assign maj = (a & b) | (a & c) | (b & c);
      assign row[l+1][2*g]   = a ^ b ^ c;
      // Carry moves up one weight, the top bit drops out.
      assign row[l+1][2*g+1] = {maj[PROD_W-2:0], 1'b0};
    end

    // Leftover rows pass to the next level unchanged.
    for (genvar r = 0; r < N % 3; r++) begin : g_pass
      assign row[l+1][2*G+r] = row[l][3*G+r];
    end
  end

  assign csa_o.sum   = row[LVLS][0];
  assign csa_o.carry = row[LVLS][1];

endmodule

/* rtl/mul_result_sel.sv */
`timescale 1ns/1ps

module mul_result_sel import mul_pkg::*; (
  input  csa_pair_t       csa_i,
  input  mul_op_e         op_i,
  output logic [XLEN-1:0] result_o
);

  logic [PROD_W-1:0] product;
  logic [XLEN-1:0]   prod_lo;
  logic [XLEN-1:0]   prod_hi;

  // Carry-propagate add of the redundant pair.
  assign product = csa_i.sum + csa_i.carry;

  assign prod_lo = product[XLEN-1:0];
  assign prod_hi = product[PROD_W-1:XLEN];

  // Low word for MUL, high word for the MULH family.
  always_comb begin
    case (op_i)
      MUL:     result_o = prod_lo;
      MULH,
      MULHSU,
      MULHU:   result_o = prod_hi;
      default: result_o = prod_hi;
    endcase
  end

endmodule

/* rtl/mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe import mul_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  csa_pair_t       csa_i,
  input  mul_op_e         op_i,
  output csa_pair_t       csa_o,
  output mul_op_e         op_o,
  input  logic [XLEN-1:0] result_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output logic [XLEN-1:0] rsp_data_o
);

  logic            advance;
  logic            s1_valid;
  csa_pair_t       s1_csa;
  mul_op_e         s1_op;
  logic            s2_valid;
  logic [XLEN-1:0] s2_data;

  // Whole pipe moves when the output slot is free or being drained.
  assign advance     = !s2_valid || rsp_ready_i;
  assign req_ready_o = advance;

  // *********************************************************************
  // Valid bits.
  // *********************************************************************
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= req_valid_i;
      s2_valid <= s1_valid;
    end
  end

  // *********************************************************************
  // Payload.
  // *********************************************************************
  always_ff @(posedge clk_i) begin
    if (advance && req_valid_i) begin
      s1_csa <= csa_i;
      s1_op  <= op_i;
    end
  end

  // Result held while stalled.
  always_ff @(posedge clk_i) begin
    if (advance && s1_valid) begin
      s2_data <= result_i;
    end
  end

  assign csa_o       = s1_csa;
  assign op_o        = s1_op;
  assign rsp_valid_o = s2_valid;
  assign rsp_data_o  = s2_data;

endmodule

/* rtl/mul_top.sv */
`timescale 1ns/1ps

module mul_top import mul_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  mul_req_t        req_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output logic [XLEN-1:0] rsp_data_o
);

  pp_array_t       pp;
  csa_pair_t       csa_comb;
  csa_pair_t       csa_s1;
  mul_op_e         op_s1;
  logic [XLEN-1:0] result;

  // *********************************************************************
  // Stage 1, Booth rows and reduction.
  // *********************************************************************
  mul_booth_r4 u_booth (
    .req_i (req_i),
    .pp_o  (pp)
  );

  mul_csa_tree u_tree (
    .pp_i  (pp),
    .csa_o (csa_comb)
  );

  mul_pipe u_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .csa_i       (csa_comb),
    .op_i        (req_i.op),
    .csa_o       (csa_s1),
    .op_o        (op_s1),
    .result_i    (result),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

  // Stage 2, final add and word select.
  mul_result_sel u_sel (
    .csa_i    (csa_s1),
    .op_i     (op_s1),
    .result_o (result)
  );

endmodule

/* verif/mul_top_sva.sv */
`timescale 1ns/1ps

module mul_top_sva import mul_pkg::*; (
  input logic            clk_i,
  input logic            rst_i,
  input logic            req_valid_i,
  input logic            req_ready_i,
  input logic            rsp_valid_i,
  input logic            rsp_ready_i,
  input logic [XLEN-1:0] rsp_data_i
);

  logic acc_d;

  // Request accepted on the previous edge.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      acc_d <= 1'b0;
    end else begin
      acc_d <= req_valid_i && req_ready_i;
    end
  end

  // **********************************************************************
  // Handshake and reset rules.
  // **********************************************************************
  a_rsp_low_after_reset: assert property (@(posedge clk_i) rst_i |=> !rsp_valid_i)
    else $error("rsp_valid_o high in the cycle after reset");

  a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
    else $error("rsp_data_o or rsp_valid_o changed while stalled");

  // Second stage loads on the edge after acceptance when the output drains.
  a_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    acc_d && rsp_ready_i |=> rsp_valid_i)
    else $error("response missing two cycles after acceptance");

endmodule

bind mul_top mul_top_sva u_sva (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .rsp_valid_i (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_data_i  (rsp_data_o)
);

/* verif/tb_mul_top.sv */
`timescale 1ns/1ps

module tb_mul_top import mul_pkg::*; ();

  localparam int SEED_INIT   = 47;
  localparam int N_RANDOM    = 200;
  localparam int N_THROTTLE  = 100;
  // Tests take about 1100 cycles, so this leaves a margin of four.
  localparam int TIMEOUT_CYC = 5000;

  logic            clk_i;
  logic            rst_i;
  logic            req_valid_i;
  logic            req_ready_o;
  mul_req_t        req_i;
  logic            rsp_valid_o;
  logic            rsp_ready_i;
  logic [XLEN-1:0] rsp_data_o;

  integer          seed;
  int              cycle;
  logic            check_lat;
  logic [XLEN-1:0] exp_q[$];
  mul_req_t        req_q[$];
  int              acc_q[$];
  logic [XLEN-1:0] corners [5] = '{32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF,
                                   32'h8000_0000, 32'h7FFF_FFFF};

  mul_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_data_o  (rsp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // **********************************************************************
  // Reference model and helpers.
  // **********************************************************************
  // Full 64-bit product of the operands extended as RV32M defines them.
  function automatic logic [XLEN-1:0] ref_mul(input mul_req_t r);
    logic [PROD_W-1:0] a;
    logic [PROD_W-1:0] b;
    logic [PROD_W-1:0] p;
    a = {{XLEN{1'b0}}, r.rs1};
    b = {{XLEN{1'b0}}, r.rs2};
    if (r.op != MULHU) begin
      a = {{XLEN{r.rs1[XLEN-1]}}, r.rs1};
    end
    if (r.op == MUL || r.op == MULH) begin
      b = {{XLEN{r.rs2[XLEN-1]}}, r.rs2};
    end
    p = a * b;
    return (r.op == MUL) ? p[XLEN-1:0] : p[PROD_W-1:XLEN];
  endfunction

  function automatic mul_req_t rand_req();
    mul_req_t    r;
    logic [31:0] sel;
    sel   = $random(seed);
    r.op  = mul_op_e'(sel[1:0]);
    r.rs1 = $random(seed);
    r.rs2 = $random(seed);
    return r;
  endfunction

  task automatic compare(input logic [63:0] act, input logic [63:0] exp_val,
                         input string what);
    if (act !== exp_val) begin
      $display("** Error at %0d ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, act, exp_val);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  task automatic send_req(input mul_req_t r);
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = r;
    #1;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic go_idle();
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // **********************************************************************
  // Monitor, sampled between the falling and the rising edge.
  // **********************************************************************
  initial begin
    logic [XLEN-1:0] exp_val;
    mul_req_t        req;
    int              acc;
    cycle = 0;
    forever begin
      @(negedge clk_i);
      #1;
      cycle++;
      if (cycle >= TIMEOUT_CYC) begin
        $display("Timeout, the run went past %0d cycles", TIMEOUT_CYC);
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
      end
      if (!rst_i && req_valid_i && req_ready_o) begin
        exp_q.push_back(ref_mul(req_i));
        req_q.push_back(req_i);
        acc_q.push_back(cycle);
      end
      if (!rst_i && rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("A response transferred with no request outstanding");
          $display("ERRORS FOUND");
          $fatal(1, "unexpected response");
        end
        exp_val = exp_q.pop_front();
        req     = req_q.pop_front();
        acc     = acc_q.pop_front();
        compare(64'(rsp_data_o), 64'(exp_val),
                $sformatf("%s rs1=%h rs2=%h", req.op.name(), req.rs1, req.rs2));
        if (check_lat) begin
          compare(64'(cycle - acc), 64'd2, "response latency");
        end
      end
    end
  end

  // **********************************************************************
  // Directed tests.
  // **********************************************************************
  // Output side is still held off, so ready must come from an empty stage 2.
  task automatic reset_state_test();
    #1;
    compare(64'(rsp_valid_o), 64'd0, "rsp_valid_o after reset");
    compare(64'(req_ready_o), 64'd1, "req_ready_o after reset");
    @(negedge clk_i);
    rsp_ready_i = 1'b1;
  endtask

  task automatic corner_test();
    mul_req_t r;
    int       k;
    int       i;
    int       j;
    check_lat = 1'b1;
    for (k = 0; k < 4; k++) begin
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          r.op  = mul_op_e'(k[1:0]);
          r.rs1 = corners[3'(i)];
          r.rs2 = corners[3'(j)];
          send_req(r);
          go_idle();
          drain();
        end
      end
    end
  endtask

  task automatic random_test(input int n_ops);
    check_lat = 1'b1;
    repeat (n_ops) send_req(rand_req());
    go_idle();
    drain();
  endtask

  task automatic backpressure_test();
    logic [XLEN-1:0] held;
    check_lat = 1'b0;
    @(negedge clk_i);
    rsp_ready_i = 1'b0;
    send_req(rand_req());
    send_req(rand_req());
    fork
      begin
        send_req(rand_req());
        send_req(rand_req());
      end
      begin
        @(negedge clk_i);
        #2;
        compare(64'(req_ready_o), 64'd0, "req_ready_o with both stages full");
        compare(64'(rsp_valid_o), 64'd1, "rsp_valid_o with both stages full");
        held = rsp_data_o;
        repeat (6) begin
          @(negedge clk_i);
          #2;
          compare(64'(rsp_data_o), 64'(held), "rsp_data_o while stalled");
          compare(64'(req_ready_o), 64'd0, "req_ready_o while stalled");
        end
        @(negedge clk_i);
        rsp_ready_i = 1'b1;
      end
    join
    go_idle();
    drain();
  endtask

  task automatic throttle_test(input int n_ops);
    logic [31:0] coin;
    logic        free;
    int          sent;
    check_lat = 1'b0;
    free = 1'b1;
    sent = 0;
    while (sent < n_ops) begin
      @(negedge clk_i);
      coin = $random(seed);
      rsp_ready_i = coin[0];
      // A request that was not taken is held unchanged.
      if (free) begin
        coin = $random(seed);
        req_valid_i = coin[0];
        if (coin[0]) begin
          req_i = rand_req();
        end
      end
      #1;
      free = !req_valid_i || req_ready_o;
      if (req_valid_i && req_ready_o) begin
        sent++;
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    drain();
  endtask

  initial begin
    seed        = SEED_INIT;
    check_lat   = 1'b0;
    rst_i       = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_i = 1'b0;
    reset_state_test();
    corner_test();
    random_test(N_RANDOM);
    backpressure_test();
    throttle_test(N_THROTTLE);
    repeat (5) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      $display("%0d responses never arrived", exp_q.size());
      $display("ERRORS FOUND");
      $fatal(1, "missing responses");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* verilog.f */
rtl/mul_pkg.sv
rtl/mul_booth_r4.sv
rtl/mul_csa_tree.sv
rtl/mul_result_sel.sv
rtl/mul_pipe.sv
rtl/mul_top.sv
verif/mul_top_sva.sv
verif/tb_mul_top.sv

/* run.sh */
#!/bin/sh
# Build the simulation with Verilator and run it.
# The exit status of the run is the verdict.
verilator --binary --timing --assert --top-module tb_mul_top -f verilog.f -o sim_mul_top \
  && ./obj_dir/sim_mul_top \
  || exit 1
